// ==== compile.f ====
+incdir+include
hw/panda_param_pkg.sv
hw/panda_stream_pkg.sv
hw/panda_region_map.sv
hw/panda_packet_counter.sv
hw/panda_output_drain.sv
hw/panda_load_sequencer.sv
hw/panda_ctrl_top.sv
verification/tb_panda_ctrl.sv

// ==== Bender.yml ====
package:
  name: panda_ctrl

sources:
  # Packages ahead of the modules that import them
  - hw/panda_param_pkg.sv
  - hw/panda_stream_pkg.sv
  - hw/panda_region_map.sv
  - hw/panda_packet_counter.sv
  - hw/panda_output_drain.sv
  - hw/panda_load_sequencer.sv
  - hw/panda_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_panda_ctrl.sv

// ==== include/tb_panda_tasks.svh ====
// Directed tests and typed compare helpers of the controller testbench.
// Included inside the testbench module, so it sees the DUT signals and tallies.
`ifndef TB_PANDA_TASKS_SVH
`define TB_PANDA_TASKS_SVH

// Packets a region should get in a given mode
function automatic len_t expected_pkts(input mem_sel_e sel, input mode_t mode);
   if (sel == NULL) return '0;
   if (sel == WEIGHT_CONV && mode != MODE_CONV) return '0;
   if (sel == WEIGHT_FC && mode != MODE_CONV && mode != MODE_FC) return '0;
   return params_i[(int'(sel) - 1) * 3];
endfunction

function automatic int full_run_pkts();
   int sum;
   sum = int'(params_i[OUTPUT_N]);
   for (int s = 1; s < 8; s++) sum += int'(params_i[(s - 1) * 3]);
   return sum;
endfunction

task automatic check_len(input string what, input len_t exp, input len_t act);
   if (exp !== act) begin
      $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      mism_cnt++;
   end
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
   if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      mism_cnt++;
   end
endtask

task automatic check_sel(input string what, input mem_sel_e exp, input mem_sel_e act);
   if (exp !== act) begin
      $display("mismatch %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
      mism_cnt++;
   end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
   if (exp !== act) begin
      $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      mism_cnt++;
   end
endtask

task automatic clear_tallies();
   for (int s = 0; s < 8; s++) begin
      pkt_cnt[s] = '0;
      req_cnt[s] = '0;
   end
   {pkt_total, start_pkts, out_cnt, start_cnt, done_cnt} = '0;
   last_sel = NULL;
endtask

task automatic pulse_start(input mode_t mode);
   @(posedge clk_i);
   mode_i  <= mode;
   start_i <= 1'b1;
   @(posedge clk_i);
   start_i <= 1'b0;
endtask

// Full pass, engine finishes once all results are drained
task automatic run_once(input mode_t mode, input logic hold_a);
   clear_tallies();
   pulse_start(mode);
   while (out_cnt < params_i[OUTPUT_N]) @(posedge clk_i);
   if (hold_a) a_ready_start_i <= 1'b0;   // Source A still busy
   engine_done_i <= 1'b1;
   @(posedge clk_i);
   engine_done_i <= 1'b0;
   if (hold_a) begin
      repeat (5) @(posedge clk_i);
      check_len("done while source busy", '0, done_cnt);
      a_ready_start_i <= 1'b1;
   end
   while (done_cnt == 0) @(posedge clk_i);
   @(negedge clk_i);
   check_bit("engine clear after done", 1'b1, engine_clear_o);
   check_bit("done width", 1'b0, done_o);
endtask

task automatic check_run(input mode_t mode);
   len_t     total;
   mem_sel_e sel;
   total = '0;
   for (int s = 1; s < 8; s++) begin
      sel = mem_sel_e'(s);
      check_len($sformatf("%s packets", sel.name()), expected_pkts(sel, mode), pkt_cnt[s]);
      total += expected_pkts(sel, mode);
   end
   check_len("NULL packets", '0, pkt_cnt[NULL]);
   check_len("packets before engine start", total, start_pkts);
   check_len("output packets", params_i[OUTPUT_N], out_cnt);
   check_len("engine start cycles", 1, start_cnt);
   check_len("done cycles", 1, done_cnt);
endtask

task automatic test_reset_values();
   test_name = "reset";
   @(negedge clk_i);
   check_bit("a req", 1'b0, a_req_start_o);
   check_bit("b req", 1'b0, b_req_start_o);
   check_bit("c req", 1'b0, c_req_start_o);
   check_bit("stream ready", 1'b0, stream_ready_o);
   check_bit("out ready", 1'b0, out_ready_o);
   check_bit("engine start", 1'b0, engine_start_o);
   check_bit("engine enable", 1'b0, engine_enable_o);
   check_bit("engine clear", 1'b1, engine_clear_o);
   check_bit("done", 1'b0, done_o);
   check_sel("mem sel", NULL, mem_sel_o);
endtask

task automatic test_conv_mode();
   test_name = "conv mode";
   run_once(MODE_CONV, 1'b0);
   check_run(MODE_CONV);
endtask

task automatic test_fc_mode();
   test_name = "fc mode";
   run_once(MODE_FC, 1'b0);
   check_run(MODE_FC);
   test_name = "mode 2";
   run_once(2'd2, 1'b0);
   check_run(2'd2);
endtask

task automatic test_run_drain();
   test_name = "run and drain";
   @(posedge clk_i);
   params_i[OUTPUT_N] <= 6;              // Longer drain than the default
   run_once(MODE_CONV, 1'b0);
   check_run(MODE_CONV);
   @(posedge clk_i);
   params_i[OUTPUT_N] <= 4;
endtask

task automatic test_termination();
   test_name = "termination";
   run_once(MODE_FC, 1'b1);
   check_run(MODE_FC);
endtask

task automatic test_zero_and_clear();
   param_word_t lut_n;
   test_name = "zero length";
   lut_n = params_i[LUT_N];
   @(posedge clk_i);
   params_i[LUT_N] <= '0;
   run_once(MODE_CONV, 1'b0);
   check_run(MODE_CONV);
   check_len("LUT requests", '0, req_cnt[LUT]);
   @(posedge clk_i);
   params_i[LUT_N] <= lut_n;
   // Abort in the middle of the sparsity region
   test_name = "soft clear";
   clear_tallies();
   pulse_start(MODE_CONV);
   while (mem_sel_o != SPARSITY) @(negedge clk_i);
   @(posedge clk_i);
   clear_i <= 1'b1;
   @(posedge clk_i);
   clear_i <= 1'b0;
   @(negedge clk_i);
   check_bit("engine clear", 1'b1, engine_clear_o);
   check_sel("mem sel", NULL, mem_sel_o);
   run_once(MODE_CONV, 1'b0);
   check_run(MODE_CONV);
endtask

`endif

// ==== verification/tb_panda_ctrl.sv ====
// Testbench of the load-and-run controller. Models the A/B/C streamers with
// random valids, tallies handshakes per memory region and runs the directed tests.
module tb_panda_ctrl;
   import panda_param_pkg::*;
   import panda_stream_pkg::*;

   localparam int NB_FULL_RUNS = 7; // Upper bound on whole load-and-run passes

   logic        clk_i, rst_ni, clear_i, start_i, engine_done_i;
   logic        a_ready_start_i, b_ready_start_i, c_ready_start_i;
   logic        a_valid_i, b_valid_i, c_valid_i;
   param_word_t params_i [PANDA_NB_PARAMS];
   mode_t       mode_i;
   logic        a_req_start_o, b_req_start_o, c_req_start_o;
   addr_t       a_base_addr_o, b_base_addr_o, c_base_addr_o;
   len_t        src_len_o, out_len_o;
   logic        stream_ready_o, out_ready_o;
   mem_sel_e    mem_sel_o;
   logic        engine_clear_o, engine_enable_o, engine_start_o, done_o;

   len_t        pkt_cnt [8];     // Memory writes per select code
   len_t        req_cnt [8];     // Source start requests per select code
   len_t        pkt_total, start_pkts, out_cnt, start_cnt, done_cnt;
   mem_sel_e    last_sel;
   int          mism_cnt = 0;
   int          other_cnt = 0;
   int          cycle_cnt = 0;
   int          limit;
   string       test_name;
   logic [31:0] rnd = 32'h57e2;

   panda_ctrl_top UUT (.*);

   `include "tb_panda_tasks.svh"

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // Streamers present data about three cycles in four
   always @(posedge clk_i) begin
      rnd       <= xorshift(rnd);
      a_valid_i <= rnd[0] | rnd[1];
      b_valid_i <= rnd[2] | rnd[3];
      c_valid_i <= rnd[4] | rnd[5];
   end

   // Monitor, sampled mid-cycle where outputs are settled
   always @(negedge clk_i) begin
      if (rst_ni) begin
         if (mem_sel_o != NULL) begin
            check_len("src len", params_i[(int'(mem_sel_o) - 1) * 3], src_len_o);
            check_addr("a base", params_i[(int'(mem_sel_o) - 1) * 3 + 1], a_base_addr_o);
            check_addr("b base", params_i[(int'(mem_sel_o) - 1) * 3 + 2], b_base_addr_o);
         end
         if (stream_ready_o) begin
            check_bit("engine enable", 1'b1, engine_enable_o);
            if (mem_sel_o < last_sel) begin
               $display("%s: packet for %s came after %s, out of load order",
                        test_name, mem_sel_o.name(), last_sel.name());
               other_cnt++;
            end
            last_sel = mem_sel_o;
            pkt_cnt[mem_sel_o]++;
            pkt_total++;
         end
         if (a_req_start_o || b_req_start_o) req_cnt[mem_sel_o]++;
         if (c_req_start_o && out_cnt != 0) begin
            $display("%s: sink start requested again after the first result", test_name);
            other_cnt++;
         end
         if (out_ready_o) begin
            check_len("out len", params_i[OUTPUT_N], out_len_o);
            check_addr("c base", params_i[OUTPUT_ADDR], c_base_addr_o);
            out_cnt++;
         end
         if (engine_start_o) begin
            check_bit("engine enable at start", 1'b1, engine_enable_o);
            start_cnt++;
            start_pkts = pkt_total;           // Everything loaded by now
         end
         if (done_o) begin
            check_bit("engine enable in terminate", 1'b0, engine_enable_o);
            done_cnt++;
         end
      end
   end

   // Run limit
   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt > limit) begin
         $display("%s: run stopped, still busy after %0d cycles", test_name, cycle_cnt);
         $display("errors: %0d mismatches, %0d other", mism_cnt, other_cnt + 1);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      rst_ni = 1'b0;
      clear_i = 1'b0;
      start_i = 1'b0;
      engine_done_i = 1'b0;
      a_ready_start_i = 1'b1;
      b_ready_start_i = 1'b1;
      c_ready_start_i = 1'b1;
      a_valid_i = 1'b0;
      b_valid_i = 1'b0;
      c_valid_i = 1'b0;
      mode_i = MODE_CONV;
      for (int r = 0; r < 7; r++) begin
         params_i[r * 3]     = 2 + (r % 5);                 // 2 to 6 packets
         params_i[r * 3 + 1] = 32'h1000_0000 + r * 32'h100;
         params_i[r * 3 + 2] = 32'h2000_0000 + r * 32'h100;
      end
      params_i[OUTPUT_N]    = 4;
      params_i[OUTPUT_ADDR] = 32'h3000_0000;
      limit = 20 * NB_FULL_RUNS * full_run_pkts() + 200;
      clear_tallies();
      repeat (5) @(posedge clk_i);
      rst_ni <= 1'b1;
      test_reset_values();
      test_conv_mode();
      test_fc_mode();
      test_run_drain();
      test_termination();
      test_zero_and_clear();
      $display("errors: %0d mismatches, %0d other", mism_cnt, other_cnt);
      if (mism_cnt == 0 && other_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== hw/panda_ctrl_top.sv ====
// Load-and-run controller of the accelerator wrapper.
// Fills the accelerator memories from the A/B source streams, runs the engine
// and drains its results to the C sink. Loose streamer and engine ports.
module panda_ctrl_top
   import panda_param_pkg::*;
   import panda_stream_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_ni,
   input  logic        clear_i,
   input  logic        start_i,
   input  param_word_t params_i [PANDA_NB_PARAMS],
   input  mode_t       mode_i,
   input  logic        engine_done_i,
   // Streamer flags
   input  logic        a_ready_start_i,
   input  logic        b_ready_start_i,
   input  logic        c_ready_start_i,
   input  logic        a_valid_i,
   input  logic        b_valid_i,
   input  logic        c_valid_i,
   // Streamer control
   output logic        a_req_start_o,
   output logic        b_req_start_o,
   output logic        c_req_start_o,
   output addr_t       a_base_addr_o,
   output addr_t       b_base_addr_o,
   output addr_t       c_base_addr_o,
   output len_t        src_len_o,
   output len_t        out_len_o,
   output logic        stream_ready_o,  // Also the memory write enable
   output logic        out_ready_o,
   output mem_sel_e    mem_sel_o,
   // Engine control
   output logic        engine_clear_o,
   output logic        engine_enable_o,
   output logic        engine_start_o,
   output logic        done_o
);

   seq_state_e state;
   logic       load_active;
   logic       drain_active;
   logic       region_done;

   panda_load_sequencer i_sequencer (
      .clk_i, .rst_ni, .clear_i, .start_i, .mode_i, .engine_done_i,
      .region_done_i   (region_done),
      .a_ready_start_i, .b_ready_start_i,
      .state_o         (state),
      .load_active_o   (load_active),
      .drain_active_o  (drain_active),
      .engine_clear_o, .engine_enable_o, .engine_start_o, .done_o
   );

   panda_region_map i_region_map (
      .state_i      (state),
      .params_i,
      .region_len_o (src_len_o),
      .a_base_o     (a_base_addr_o),
      .b_base_o     (b_base_addr_o),
      .out_len_o,
      .out_base_o   (c_base_addr_o),
      .mem_sel_o
   );

   panda_packet_counter i_packet_counter (
      .clk_i, .rst_ni, .clear_i,
      .load_active_i (load_active),
      .region_len_i  (src_len_o),
      .a_valid_i, .b_valid_i, .a_ready_start_i, .b_ready_start_i,
      .stream_ready_o,
      .region_done_o (region_done),
      .a_req_start_o, .b_req_start_o
   );

   panda_output_drain i_output_drain (
      .clk_i, .rst_ni, .clear_i,
      .drain_active_i (drain_active),
      .out_len_i      (out_len_o),
      .c_valid_i, .c_ready_start_i,
      .out_ready_o, .c_req_start_o
   );

endmodule

// ==== hw/panda_load_sequencer.sv ====
// Top FSM of the controller: walks the memory regions in load order,
// starts the engine, waits for its done flag and then for idle sources.
// Region progress comes from the packet counter as a level.
module panda_load_sequencer
   import panda_param_pkg::*;
   import panda_stream_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       clear_i,          // Soft clear back to IDLE
   input  logic       start_i,          // Start strobe from the register file
   input  mode_t      mode_i,
   input  logic       engine_done_i,
   input  logic       region_done_i,    // Current region fully transferred
   input  logic       a_ready_start_i,
   input  logic       b_ready_start_i,
   output seq_state_e state_o,
   output logic       load_active_o,    // Any of the seven load states
   output logic       drain_active_o,   // Output sink phase
   output logic       engine_clear_o,
   output logic       engine_enable_o,
   output logic       engine_start_o,
   output logic       done_o
);

   seq_state_e state_q, state_d;
   logic       srcs_idle;

   assign srcs_idle = a_ready_start_i && b_ready_start_i; // Both sources can take a new job

   // State register
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= IDLE;
      end else if (clear_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Next state
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start_i) state_d = LOAD_CONFIG;
         end
         LOAD_CONFIG: begin
            if (region_done_i) state_d = LOAD_INSTR;
         end
         LOAD_INSTR: begin
            if (region_done_i) state_d = LOAD_LUT;
         end
         LOAD_LUT: begin
            if (region_done_i) state_d = LOAD_SPARSITY;
         end
         LOAD_SPARSITY: begin
            if (region_done_i) state_d = LOAD_ACTIVATION;
         end
         LOAD_ACTIVATION: begin
            // Weight regions depend on the layer type
            if (region_done_i) begin
               if (mode_i == MODE_CONV) begin
                  state_d = LOAD_WEIGHT_CONV;
               end else if (mode_i == MODE_FC) begin
                  state_d = LOAD_WEIGHT_FC;
               end else begin
                  state_d = ACCEL_RUN; // No weights to load
               end
            end
         end
         LOAD_WEIGHT_CONV: begin
            if (region_done_i) state_d = LOAD_WEIGHT_FC; // Conv always continues to FC
         end
         LOAD_WEIGHT_FC: begin
            if (region_done_i) state_d = ACCEL_RUN;
         end
         ACCEL_RUN: begin
            state_d = ACCEL_RUNNING; // One cycle only
         end
         ACCEL_RUNNING: begin
            if (engine_done_i) state_d = TERMINATE;
         end
         TERMINATE: begin
            if (srcs_idle) state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // Phase levels for the counters
   assign load_active_o  = state_q inside {LOAD_CONFIG, LOAD_INSTR, LOAD_LUT, LOAD_SPARSITY,
                                           LOAD_ACTIVATION, LOAD_WEIGHT_CONV, LOAD_WEIGHT_FC};
   assign drain_active_o = (state_q == ACCEL_RUNNING);

   // Engine controls
   assign engine_clear_o  = (state_q == IDLE);                        // Held in reset while idle
   assign engine_enable_o = (state_q != IDLE) && (state_q != TERMINATE);
   assign engine_start_o  = (state_q == ACCEL_RUN);

   // Done in the cycle that returns to IDLE
   assign done_o = (state_q == TERMINATE) && srcs_idle;

   assign state_o = state_q;

endmodule

// ==== hw/panda_output_drain.sv ====
// Counts result handshakes on the output sink while the engine runs
// and requests the sink start before the first result packet.
// Stops accepting once the output size is reached.
module panda_output_drain
   import panda_stream_pkg::*;
(
   input  logic clk_i,
   input  logic rst_ni,
   input  logic clear_i,
   input  logic drain_active_i,   // Sequencer in ACCEL_RUNNING
   input  len_t out_len_i,
   input  logic c_valid_i,
   input  logic c_ready_start_i,
   output logic out_ready_o,
   output logic c_req_start_o
);

   len_t cnt_q;
   logic clr_q;
   logic cnt_full;

   assign cnt_full = (cnt_q == out_len_i); // Count holds here until the run ends

   assign out_ready_o = drain_active_i && !clr_q && !cnt_full && c_valid_i;

   // Only before the first result, never again in the same run
   assign c_req_start_o = drain_active_i && !clr_q && !cnt_full && (cnt_q == '0)
                          && c_ready_start_i;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         clr_q <= 1'b1;
         cnt_q <= '0;
      end else if (clear_i) begin
         clr_q <= 1'b1;
         cnt_q <= '0;
      end else begin
         clr_q <= !drain_active_i;        // Cleared outside the run
         if (clr_q) begin
            cnt_q <= '0;
         end else if (out_ready_o) begin
            cnt_q <= cnt_q + len_t'(1);
         end
      end
   end

endmodule

// ==== hw/panda_packet_counter.sv ====
// Counts address/data handshakes of the region being loaded and raises
// the start requests of both source streams at the beginning of a region.
// Every cycle with stream_ready_o high is one memory write.
module panda_packet_counter
   import panda_stream_pkg::*;
(
   input  logic clk_i,
   input  logic rst_ni,
   input  logic clear_i,
   input  logic load_active_i,    // Sequencer in a load state
   input  len_t region_len_i,
   input  logic a_valid_i,
   input  logic b_valid_i,
   input  logic a_ready_start_i,
   input  logic b_ready_start_i,
   output logic stream_ready_o,
   output logic region_done_o,
   output logic a_req_start_o,
   output logic b_req_start_o
);

   len_t cnt_q;
   logic clr_q, clr_d;   // Registered counter clear
   logic cnt_full;       // All packets of the region seen

   assign cnt_full      = (cnt_q == region_len_i);
   assign region_done_o = cnt_full && !clr_q;     // Stale count ignored while clearing

   // Clear for the next cycle unless loading continues
   assign clr_d = !load_active_i || region_done_o;

   // One packet per cycle with both streams valid
   assign stream_ready_o = load_active_i && !clr_q && !cnt_full && a_valid_i && b_valid_i;

   // Kick both sources before the first packet
   assign a_req_start_o = load_active_i && !clr_q && !region_done_o && (cnt_q == '0)
                          && a_ready_start_i && b_ready_start_i;
   assign b_req_start_o = a_req_start_o; // Both sources start together

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         clr_q <= 1'b1;
         cnt_q <= '0;
      end else if (clear_i) begin
         clr_q <= 1'b1;
         cnt_q <= '0;
      end else begin
         clr_q <= clr_d;
         if (clr_q) begin
            cnt_q <= '0;                  // Region entry
         end else if (stream_ready_o) begin
            cnt_q <= cnt_q + len_t'(1);
         end
      end
   end

endmodule

// ==== hw/panda_region_map.sv ====
// Decodes the sequencer state into the transfer setup of the current region:
// size, source base addresses, memory select and the output sink setup.
// Purely combinational.
module panda_region_map
   import panda_param_pkg::*;
   import panda_stream_pkg::*;
(
   input  seq_state_e  state_i,
   input  param_word_t params_i [PANDA_NB_PARAMS],
   output len_t        region_len_o,  // Source transfer size
   output addr_t       a_base_o,      // Address stream base
   output addr_t       b_base_o,      // Data stream base
   output len_t        out_len_o,     // Sink transfer size
   output addr_t       out_base_o,    // Sink base
   output mem_sel_e    mem_sel_o
);

   always_comb begin
      // Zero and NULL unless a region or the run is active
      region_len_o = '0;
      a_base_o     = '0;
      b_base_o     = '0;
      out_len_o    = '0;
      out_base_o   = '0;
      mem_sel_o    = NULL;
      unique case (state_i)
         LOAD_CONFIG: begin
            region_len_o = params_i[CONFIG_N];
            a_base_o     = params_i[CONFIG_A];
            b_base_o     = params_i[CONFIG_D];
            mem_sel_o    = CONFIG;
         end
         LOAD_INSTR: begin
            region_len_o = params_i[INSTR_N];
            a_base_o     = params_i[INSTR_A];
            b_base_o     = params_i[INSTR_D];
            mem_sel_o    = INSTR;
         end
         LOAD_LUT: begin
            region_len_o = params_i[LUT_N];
            a_base_o     = params_i[LUT_A];
            b_base_o     = params_i[LUT_D];
            mem_sel_o    = LUT;
         end
         LOAD_SPARSITY: begin
            region_len_o = params_i[SPARSITY_N];
            a_base_o     = params_i[SPARSITY_A];
            b_base_o     = params_i[SPARSITY_D];
            mem_sel_o    = SPARSITY;
         end
         LOAD_ACTIVATION: begin
            region_len_o = params_i[ACTIVATION_N];
            a_base_o     = params_i[ACTIVATION_A];
            b_base_o     = params_i[ACTIVATION_D];
            mem_sel_o    = ACTIVATION;
         end
         LOAD_WEIGHT_CONV: begin
            region_len_o = params_i[WEIGHT_CONV_N];
            a_base_o     = params_i[WEIGHT_CONV_A];
            b_base_o     = params_i[WEIGHT_CONV_D];
            mem_sel_o    = WEIGHT_CONV;
         end
         LOAD_WEIGHT_FC: begin
            region_len_o = params_i[WEIGHT_FC_N];
            a_base_o     = params_i[WEIGHT_FC_A];
            b_base_o     = params_i[WEIGHT_FC_D];
            mem_sel_o    = WEIGHT_FC;
         end
         ACCEL_RUN, ACCEL_RUNNING: begin
            out_len_o  = params_i[OUTPUT_N];    // Sink setup valid one cycle before draining
            out_base_o = params_i[OUTPUT_ADDR];
         end
         default: ;
      endcase
   end

endmodule

// ==== hw/panda_stream_pkg.sv ====
// Stream-side types shared by the load-and-run controller.
// Address and length words of the source and sink streams, plus sequencer states.
package panda_stream_pkg;

   typedef logic [31:0] addr_t;       // Byte address
   typedef logic [31:0] len_t;        // Length in packets
   typedef logic [31:0] param_word_t; // One register-file word

   // Load order, then run and terminate
   typedef enum logic [3:0] {
      IDLE,
      LOAD_CONFIG,
      LOAD_INSTR,
      LOAD_LUT,
      LOAD_SPARSITY,
      LOAD_ACTIVATION,
      LOAD_WEIGHT_CONV,
      LOAD_WEIGHT_FC,
      ACCEL_RUN,       // Single-cycle engine start
      ACCEL_RUNNING,   // Output drained until engine done
      TERMINATE        // Wait for sources idle
   } seq_state_e;

endpackage

// ==== hw/panda_param_pkg.sv ====
// Register-file layout of the accelerator wrapper parameter words.
// Word indices per memory region, memory demux select codes and engine modes.
// Import wherever the parameter array or the memory select is decoded.
package panda_param_pkg;

   localparam int unsigned PANDA_NB_PARAMS = 23; // Total parameter words

   // Regions in load order, each as size N, address-stream base A, data-stream base D
   localparam int unsigned CONFIG_N         = 0;
   localparam int unsigned CONFIG_A         = 1;
   localparam int unsigned CONFIG_D         = 2;
   localparam int unsigned INSTR_N          = 3;
   localparam int unsigned INSTR_A          = 4;
   localparam int unsigned INSTR_D          = 5;
   localparam int unsigned LUT_N            = 6;
   localparam int unsigned LUT_A            = 7;
   localparam int unsigned LUT_D            = 8;
   localparam int unsigned SPARSITY_N       = 9;
   localparam int unsigned SPARSITY_A       = 10;
   localparam int unsigned SPARSITY_D       = 11;
   localparam int unsigned ACTIVATION_N     = 12;
   localparam int unsigned ACTIVATION_A     = 13;
   localparam int unsigned ACTIVATION_D     = 14;
   localparam int unsigned WEIGHT_CONV_N    = 15;
   localparam int unsigned WEIGHT_CONV_A    = 16;
   localparam int unsigned WEIGHT_CONV_D    = 17;
   localparam int unsigned WEIGHT_FC_N      = 18;
   localparam int unsigned WEIGHT_FC_A      = 19;
   localparam int unsigned WEIGHT_FC_D      = 20;

   // Output sink of the run phase
   localparam int unsigned OUTPUT_N         = 21; // Result packets
   localparam int unsigned OUTPUT_ADDR      = 22; // Result base address

   // Memory demux select, NULL means no memory is written
   typedef enum logic [2:0] {
      NULL        = 3'd0,
      CONFIG      = 3'd1,
      INSTR       = 3'd2,
      LUT         = 3'd3,
      SPARSITY    = 3'd4,
      ACTIVATION  = 3'd5,
      WEIGHT_CONV = 3'd6,
      WEIGHT_FC   = 3'd7
   } mem_sel_e;

   // Engine mode as set by the host
   typedef logic [1:0] mode_t;

   localparam mode_t MODE_FC   = 2'd0; // Fully connected, FC weights only
   localparam mode_t MODE_CONV = 2'd1; // Conv weights then FC weights
   // Other codes skip weight loading

endpackage
